//--- Makefile
# Verilator build and run of the HDC item-memory testbench

LOG = sim.log

all: sim

# Build, run, then pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert -f hdc_im.f --top-module hdc_im_tb -Mdir obj_dir
	./obj_dir/Vhdc_im_tb | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	verilator --lint-only --timing --assert -f hdc_im.f --top-module hdc_im_tb

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all sim lint clean

//--- ca90_item_memory.sv
/*
 * CA90 item memory
 * Expands the seeds into all item vectors, read through one registered port
 */
`timescale 1ns/1ps
`include "hdc_im_cfg.svh"

module ca90_item_memory (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic [`HDC_NUM_SETS-1:0][`HDC_SEED_W-1:0]    seed_i,
  input  hdc_im_pkg::im_req_t                          req_i,
  output hdc_im_pkg::im_rsp_t                          rsp_o
);
  import hdc_im_pkg::*;

  // Full item table, combinational from the seeds
  logic [`HDC_HV_DIM-1:0] items [`HDC_NUM_ITEMS];
  logic                   rsp_valid_q;
  logic [`HDC_HV_DIM-1:0] rsp_data_q;

  // --------------------------------------------------------------------------
  // Hierarchical doubling of a seed into a base vector
  // --------------------------------------------------------------------------
  function automatic logic [`HDC_HV_DIM-1:0] ca90_base(
    input logic [`HDC_SEED_W-1:0] seed
  );
    logic [`HDC_HV_DIM-1:0] vec;
    logic [`HDC_HV_DIM-1:0] step;
    vec = '0;
    vec[`HDC_SEED_W-1:0] = seed;
    for (int unsigned w = `HDC_SEED_W; w < `HDC_HV_DIM; w = w * 2) begin
      // Upper half is one step of the current vector
      step = ca90_step(vec, w, 1);
      vec  = vec | (step << w);
    end
    return vec;
  endfunction

  // Item j of set s sits at s*PER_SET + j
  always_comb begin
    for (int s = 0; s < `HDC_NUM_SETS; s++) begin
      items[s*`HDC_PER_SET] = ca90_base(seed_i[s]);
      // Each later item is a fixed-shift step of the one before
      for (int j = 1; j < `HDC_PER_SET; j++) begin
        items[s*`HDC_PER_SET+j] =
          ca90_step(items[s*`HDC_PER_SET+j-1], `HDC_HV_DIM, `HDC_IM_PERM);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Registered read port, one cycle latency
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
    end
  end

  // Data only moves on a real request
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rsp_data_q <= items[req_i.idx];
    end
  end

  always_comb begin
    rsp_o.valid = rsp_valid_q;
    rsp_o.data  = rsp_data_q;
  end

endmodule

//--- hdc_apb_regs.sv
/*
 * APB register block
 * Seeds, query, unit commands, status and result copies
 */
`timescale 1ns/1ps
`include "hdc_im_cfg.svh"

module hdc_apb_regs (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  hdc_im_pkg::apb_req_t                      apb_req_i,
  output hdc_im_pkg::apb_rsp_t                      apb_rsp_o,
  output logic [`HDC_NUM_SETS-1:0][`HDC_SEED_W-1:0] seed_o,
  output logic [`HDC_HV_DIM-1:0]                    query_o,
  output logic                                      bind_start_o,
  output logic [`HDC_IDX_W-1:0]                     bind_idx_a_o,
  output logic [`HDC_IDX_W-1:0]                     bind_idx_b_o,
  input  logic                                      bind_finish_i,
  input  logic [`HDC_HV_DIM-1:0]                    bind_result_i,
  output logic                                      ham_start_o,
  output logic [`HDC_IDX_W-1:0]                     ham_idx_o,
  input  logic                                      ham_finish_i,
  input  logic [`HDC_DIST_W-1:0]                    ham_dist_i
);

  // 32-bit words per hypervector
  localparam int NUM_WORDS = `HDC_HV_DIM / 32;

  logic [`HDC_NUM_SETS-1:0][`HDC_SEED_W-1:0] seed_q;
  logic [NUM_WORDS-1:0][31:0]                query_q;
  logic [NUM_WORDS-1:0][31:0]                bind_res_q;
  logic [`HDC_DIST_W-1:0]                    ham_dist_q;
  logic [`HDC_IDX_W-1:0]                     bind_idx_a_q;
  logic [`HDC_IDX_W-1:0]                     bind_idx_b_q;
  logic [`HDC_IDX_W-1:0]                     ham_idx_q;
  logic bind_start_q;
  logic ham_start_q;
  logic bind_busy_q;
  logic ham_busy_q;
  logic bind_done_q;
  logic ham_done_q;

  logic        access;
  logic        aligned;
  logic        sel_seed;
  logic        sel_query;
  logic        sel_bind_cmd;
  logic        sel_ham_cmd;
  logic        sel_status;
  logic        sel_ham_dist;
  logic        sel_bind_res;
  logic        mapped;
  logic        slverr;
  logic        wr_en;
  logic [1:0]  word;
  logic [31:0] rdata;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  always_comb begin
    access       = apb_req_i.psel & apb_req_i.penable;
    aligned      = (apb_req_i.paddr[1:0] == 2'b00);
    word         = apb_req_i.paddr[3:2];
    // Seed, query and result occupy 16-byte windows
    sel_seed     = aligned && ((apb_req_i.paddr & 8'hF0) == `HDC_REG_SEED);
    sel_query    = aligned && ((apb_req_i.paddr & 8'hF0) == `HDC_REG_QUERY);
    sel_bind_res = aligned && ((apb_req_i.paddr & 8'hF0) == `HDC_REG_BIND_RES);
    sel_bind_cmd = (apb_req_i.paddr == `HDC_REG_BIND_CMD);
    sel_ham_cmd  = (apb_req_i.paddr == `HDC_REG_HAM_CMD);
    sel_status   = (apb_req_i.paddr == `HDC_REG_STATUS);
    sel_ham_dist = (apb_req_i.paddr == `HDC_REG_HAM_DIST);
    mapped = sel_seed | sel_query | sel_bind_res | sel_bind_cmd |
             sel_ham_cmd | sel_status | sel_ham_dist;
    // Unmapped access or command to a busy unit
    slverr = access & (~mapped |
             (apb_req_i.pwrite & ((sel_bind_cmd & bind_busy_q) |
                                  (sel_ham_cmd & ham_busy_q))));
    wr_en  = access & apb_req_i.pwrite & ~slverr;
  end

  // Read mux
  always_comb begin
    rdata = '0;
    if (sel_seed) begin
      rdata = seed_q[word];
    end else if (sel_query) begin
      rdata = query_q[word];
    end else if (sel_bind_res) begin
      rdata = bind_res_q[word];
    end else if (sel_bind_cmd) begin
      rdata[`HDC_IDX_W-1:0]  = bind_idx_a_q;
      rdata[8 +: `HDC_IDX_W] = bind_idx_b_q;
    end else if (sel_ham_cmd) begin
      rdata[`HDC_IDX_W-1:0] = ham_idx_q;
    end else if (sel_status) begin
      rdata[3:0] = {ham_done_q, bind_done_q, ham_busy_q, bind_busy_q};
    end else if (sel_ham_dist) begin
      rdata[`HDC_DIST_W-1:0] = ham_dist_q;
    end
  end

  // No wait states
  always_comb begin
    apb_rsp_o.prdata  = rdata;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = slverr;
  end

  // --------------------------------------------------------------------------
  // Register writes, start pulses, busy and done
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      seed_q       <= '0;
      query_q      <= '0;
      bind_res_q   <= '0;
      ham_dist_q   <= '0;
      bind_idx_a_q <= '0;
      bind_idx_b_q <= '0;
      ham_idx_q    <= '0;
      bind_start_q <= 1'b0;
      ham_start_q  <= 1'b0;
      bind_busy_q  <= 1'b0;
      ham_busy_q   <= 1'b0;
      bind_done_q  <= 1'b0;
      ham_done_q   <= 1'b0;
    end else begin
      bind_start_q <= 1'b0;
      ham_start_q  <= 1'b0;
      // Finish latches the result and ends busy
      if (bind_finish_i) begin
        bind_res_q  <= bind_result_i;
        bind_busy_q <= 1'b0;
        bind_done_q <= 1'b1;
      end
      if (ham_finish_i) begin
        ham_dist_q <= ham_dist_i;
        ham_busy_q <= 1'b0;
        ham_done_q <= 1'b1;
      end
      if (wr_en) begin
        if (sel_seed) begin
          seed_q[word] <= apb_req_i.pwdata;
        end
        if (sel_query) begin
          query_q[word] <= apb_req_i.pwdata;
        end
        // Busy unit never gets here, slverr blocks the write
        if (sel_bind_cmd) begin
          bind_idx_a_q <= apb_req_i.pwdata[`HDC_IDX_W-1:0];
          bind_idx_b_q <= apb_req_i.pwdata[8 +: `HDC_IDX_W];
          bind_start_q <= 1'b1;
          bind_busy_q  <= 1'b1;
          bind_done_q  <= 1'b0;
        end
        if (sel_ham_cmd) begin
          ham_idx_q   <= apb_req_i.pwdata[`HDC_IDX_W-1:0];
          ham_start_q <= 1'b1;
          ham_busy_q  <= 1'b1;
          ham_done_q  <= 1'b0;
        end
      end
    end
  end

  assign seed_o       = seed_q;
  assign query_o      = query_q;
  assign bind_start_o = bind_start_q;
  assign bind_idx_a_o = bind_idx_a_q;
  assign bind_idx_b_o = bind_idx_b_q;
  assign ham_start_o  = ham_start_q;
  assign ham_idx_o    = ham_idx_q;

endmodule

//--- hdc_im.f
+incdir+.
hdc_im_pkg.sv
ca90_item_memory.sv
im_port_arbiter.sv
hv_bind_unit.sv
hv_hamming_unit.sv
hdc_apb_regs.sv
hdc_im_top.sv
hdc_im_assertions.sv
hdc_im_tb.sv

//--- hdc_im_assertions.sv
/*
 * Item-port arbitration and command/status assertions
 */
`timescale 1ns/1ps

module hdc_im_assertions (
  input logic                clk_i,
  input logic                rst_i,
  input hdc_im_pkg::im_req_t bind_req_i,
  input hdc_im_pkg::im_req_t ham_req_i,
  input logic                bind_gnt_i,
  input logic                ham_gnt_i,
  input hdc_im_pkg::im_rsp_t bind_rsp_i,
  input hdc_im_pkg::im_rsp_t ham_rsp_i,
  input logic                bind_finish_i,
  input logic                ham_finish_i,
  input logic                bind_done_i,
  input logic                ham_done_i
);

  // --------------------------------------------------------------------------
  // Arbiter
  // --------------------------------------------------------------------------
  one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
    !(bind_gnt_i && ham_gnt_i))
    else $error("both item-port grants high");

  // Grant only to a client that asks
  bind_gnt_req: assert property (@(posedge clk_i) disable iff (rst_i)
    bind_gnt_i |-> bind_req_i.valid)
    else $error("bind grant without request");
  ham_gnt_req: assert property (@(posedge clk_i) disable iff (rst_i)
    ham_gnt_i |-> ham_req_i.valid)
    else $error("Hamming grant without request");

  // Data back to the same client one cycle later
  bind_rsp_next: assert property (@(posedge clk_i) disable iff (rst_i)
    bind_gnt_i |=> bind_rsp_i.valid)
    else $error("no bind response after grant");
  ham_rsp_next: assert property (@(posedge clk_i) disable iff (rst_i)
    ham_gnt_i |=> ham_rsp_i.valid)
    else $error("no Hamming response after grant");

  // --------------------------------------------------------------------------
  // Done bits follow a finish pulse
  // --------------------------------------------------------------------------
  bind_done_rise: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(bind_done_i) |-> $past(bind_finish_i))
    else $error("bind done set without finish");
  ham_done_rise: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ham_done_i) |-> $past(ham_finish_i))
    else $error("Hamming done set without finish");

endmodule

// Grants and requests from the top, done bits from the register block
bind hdc_im_top hdc_im_assertions hdc_im_assertions_i (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .bind_req_i    (bind_req),
  .ham_req_i     (ham_req),
  .bind_gnt_i    (bind_gnt),
  .ham_gnt_i     (ham_gnt),
  .bind_rsp_i    (bind_rsp),
  .ham_rsp_i     (ham_rsp),
  .bind_finish_i (bind_finish),
  .ham_finish_i  (ham_finish),
  .bind_done_i   (hdc_apb_regs_i.bind_done_q),
  .ham_done_i    (hdc_apb_regs_i.ham_done_q)
);

//--- hdc_im_cfg.svh
/*
 * HDC item-memory configuration
 * Vector sizes, item counts and the APB register map
 */
`ifndef HDC_IM_CFG_SVH
`define HDC_IM_CFG_SVH

// Vector geometry
`define HDC_HV_DIM      128
`define HDC_SEED_W      32
`define HDC_NUM_SETS    4
`define HDC_PER_SET     8
`define HDC_NUM_ITEMS   32
`define HDC_IDX_W       5
// CA90 shift between neighbouring items of a set
`define HDC_IM_PERM     7
`define HDC_DIST_W      8

// --------------------------------------------------------------------------
// APB register offsets
// --------------------------------------------------------------------------
`define HDC_REG_SEED     8'h00
`define HDC_REG_QUERY    8'h10
`define HDC_REG_BIND_CMD 8'h20
`define HDC_REG_HAM_CMD  8'h24
`define HDC_REG_STATUS   8'h28
`define HDC_REG_HAM_DIST 8'h2C
`define HDC_REG_BIND_RES 8'h30

`endif

//--- hdc_im_pkg.sv
/*
 * HDC item-memory package
 * Unit FSM states, port and APB structs, CA90 step
 */
`include "hdc_im_cfg.svh"

package hdc_im_pkg;

  // Compute-unit FSM, Hamming unit skips FETCH_B
  typedef enum logic [1:0] {
    IDLE,
    FETCH_A,
    FETCH_B,
    DONE
  } unit_state_e;

  // Item-memory read request
  typedef struct packed {
    logic                  valid;
    logic [`HDC_IDX_W-1:0] idx;
  } im_req_t;

  // Item-memory read response
  typedef struct packed {
    logic                   valid;
    logic [`HDC_HV_DIM-1:0] data;
  } im_rsp_t;

  // APB master to slave
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // APB slave to master
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // --------------------------------------------------------------------------
  // CA90 step on the low width bits of vec
  // --------------------------------------------------------------------------
  function automatic logic [`HDC_HV_DIM-1:0] ca90_step(
    input logic [`HDC_HV_DIM-1:0] vec,
    input int unsigned            width,
    input int unsigned            shift
  );
    logic [`HDC_HV_DIM-1:0] res;
    res = '0;
    for (int unsigned k = 0; k < `HDC_HV_DIM; k++) begin
      // Bits above width stay zero
      if (k < width) begin
        res[k] = vec[(k + shift) % width] ^ vec[(k + width - shift) % width];
      end
    end
    return res;
  endfunction

endpackage

//--- hdc_im_tb.sv
/*
 * HDC item-memory testbench
 * APB stimulus, CA90 reference model and self-checking compare
 */
`timescale 1ns/1ps
`include "hdc_im_cfg.svh"

module hdc_im_tb;
  import hdc_im_pkg::*;

  // Full run is about 1500 cycles, generous margin on top
  localparam int TIMEOUT_CYCLES = 20000;

  logic        clk;
  logic        rst;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic [31:0] lcg_state;
  logic [31:0] seed_w [`HDC_NUM_SETS];
  logic [31:0] query_w [4];
  // Pending compares, filled by the stimulus
  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];
  string       msg_q [$];
  int          n_pushed = 0;
  int          n_checked = 0;
  int          cycles = 0;
  event        cmp_ev;

  hdc_im_top hdc_im_top_i (
    .clk_i     (clk),
    .rst_i     (rst),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the test did not finish within %0d clock cycles", cycles);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  // --------------------------------------------------------------------------
  // Random numbers and reference model
  // --------------------------------------------------------------------------
  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Upper LCG bits, the low ones cycle too fast
  function int rand_idx();
    return int'(lcg_next() >> 16) % `HDC_NUM_ITEMS;
  endfunction

  function automatic logic [127:0] ca90_rule(input logic [127:0] v, input int w, input int s);
    logic [127:0] r;
    r = '0;
    for (int k = 0; k < w; k++) begin
      r[k] = v[(k + s) % w] ^ v[(k - s + w) % w];
    end
    return r;
  endfunction

  // Base vector by doubling, then the item chain inside the set
  function automatic logic [127:0] expand_item(input int idx);
    logic [127:0] v;
    int           w;
    v = 128'(seed_w[idx / `HDC_PER_SET]);
    w = `HDC_SEED_W;
    while (w < `HDC_HV_DIM) begin
      v = (ca90_rule(v, w, 1) << w) | v;
      w = w * 2;
    end
    for (int j = 0; j < idx % `HDC_PER_SET; j++) begin
      v = ca90_rule(v, `HDC_HV_DIM, `HDC_IM_PERM);
    end
    return v;
  endfunction

  // B rotated left by one
  function automatic logic [127:0] xor_rotated(input logic [127:0] ia, input logic [127:0] ib);
    logic [127:0] r;
    for (int k = 0; k < `HDC_HV_DIM; k++) begin
      r[k] = ia[k] ^ ib[(k + `HDC_HV_DIM - 1) % `HDC_HV_DIM];
    end
    return r;
  endfunction

  function automatic int count_diff_bits(input int idx);
    logic [127:0] diff;
    int           n;
    diff = expand_item(idx) ^ {query_w[3], query_w[2], query_w[1], query_w[0]};
    n = 0;
    for (int k = 0; k < `HDC_HV_DIM; k++) begin
      n += int'(diff[k]);
    end
    return n;
  endfunction

  // --------------------------------------------------------------------------
  // Checking
  // --------------------------------------------------------------------------
  task automatic compare_values(input logic [31:0] got, input logic [31:0] exp,
                                input string msg);
    if (got !== exp) begin
      $display("Fail at time %0t: %s, got %08h expected %08h", $time, msg, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic expect_value(input logic [31:0] got, input logic [31:0] exp,
                              input string msg);
    got_q.push_back(got);
    exp_q.push_back(exp);
    msg_q.push_back(msg);
    n_pushed++;
    -> cmp_ev;
  endtask

  initial begin
    forever begin
      @(cmp_ev);
      while (got_q.size() > 0) begin
        compare_values(got_q.pop_front(), exp_q.pop_front(), msg_q.pop_front());
        n_checked++;
      end
    end
  end

  // --------------------------------------------------------------------------
  // APB accesses, entered on a falling edge
  // --------------------------------------------------------------------------
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge clk);
    apb_req.penable = 1'b1;
    // Mid low phase, response settled
    #1;
    err = apb_rsp.pslverr;
    expect_value(32'(apb_rsp.pready), 32'd1, "pready in write access phase");
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1;
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    expect_value(32'(apb_rsp.pready), 32'd1, "pready in read access phase");
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  // Poll STATUS until all bits in mask are set
  task automatic wait_done(input logic [3:0] mask);
    logic [31:0] st;
    logic        err;
    st = '0;
    while ((st[3:0] & mask) != mask) begin
      read_reg(`HDC_REG_STATUS, st, err);
    end
  endtask

  task automatic bind_readback(input int a, input int b);
    logic [127:0] exp_hv;
    logic [31:0]  rdata;
    logic         err;
    exp_hv = xor_rotated(expand_item(a), expand_item(b));
    for (int w = 0; w < 4; w++) begin
      read_reg(`HDC_REG_BIND_RES + 8'(4 * w), rdata, err);
      expect_value(rdata, exp_hv[32 * w +: 32],
                   $sformatf("bind of items %0d and %0d, word %0d", a, b, w));
    end
  endtask

  task automatic dist_readback(input int idx);
    logic [31:0] rdata;
    logic        err;
    read_reg(`HDC_REG_HAM_DIST, rdata, err);
    expect_value(rdata, 32'(count_diff_bits(idx)), $sformatf("distance of item %0d", idx));
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0]  rdata;
    logic         err;
    logic [127:0] exp_hv;
    int           a;
    int           b;
    int           idx;
    lcg_state = 32'd71;
    apb_req   = '0;
    rst       = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Every mapped word is zero after reset
    for (int addr = 0; addr < 'h40; addr += 4) begin
      read_reg(8'(addr), rdata, err);
      expect_value(rdata, 32'h0, $sformatf("reset value at offset %02h", addr));
      expect_value(32'(err), 32'd0, "pslverr on mapped read");
    end

    // Seed and query readback
    for (int i = 0; i < 4; i++) begin
      seed_w[i]  = lcg_next();
      query_w[i] = lcg_next();
      write_reg(`HDC_REG_SEED + 8'(4 * i), seed_w[i], err);
      write_reg(`HDC_REG_QUERY + 8'(4 * i), query_w[i], err);
    end
    for (int i = 0; i < 4; i++) begin
      read_reg(`HDC_REG_SEED + 8'(4 * i), rdata, err);
      expect_value(rdata, seed_w[i], $sformatf("seed word %0d", i));
      read_reg(`HDC_REG_QUERY + 8'(4 * i), rdata, err);
      expect_value(rdata, query_w[i], $sformatf("query word %0d", i));
    end

    // Bind, A walks through all sets, every fifth pair binds an item to itself
    for (int i = 0; i < 40; i++) begin
      a = (i % 4) * `HDC_PER_SET + rand_idx() % `HDC_PER_SET;
      b = (i % 5 == 0) ? a : rand_idx();
      write_reg(`HDC_REG_BIND_CMD, (32'(b) << 8) | 32'(a), err);
      expect_value(32'(err), 32'd0, "pslverr on idle bind command");
      wait_done(4'b0100);
      bind_readback(a, b);
    end

    // Hamming distances
    for (int i = 0; i < 40; i++) begin
      idx = rand_idx();
      write_reg(`HDC_REG_HAM_CMD, 32'(idx), err);
      expect_value(32'(err), 32'd0, "pslverr on idle Hamming command");
      wait_done(4'b1000);
      dist_readback(idx);
    end

    // Query equal to an item gives distance zero
    idx    = rand_idx();
    exp_hv = expand_item(idx);
    for (int w = 0; w < 4; w++) begin
      query_w[w] = exp_hv[32 * w +: 32];
      write_reg(`HDC_REG_QUERY + 8'(4 * w), query_w[w], err);
    end
    write_reg(`HDC_REG_HAM_CMD, 32'(idx), err);
    wait_done(4'b1000);
    read_reg(`HDC_REG_HAM_DIST, rdata, err);
    expect_value(rdata, 32'd0, "distance of an item to itself");

    // Back-to-back commands, both units fight for the item port
    for (int i = 0; i < 20; i++) begin
      a   = rand_idx();
      b   = rand_idx();
      idx = rand_idx();
      write_reg(`HDC_REG_BIND_CMD, (32'(b) << 8) | 32'(a), err);
      write_reg(`HDC_REG_HAM_CMD, 32'(idx), err);
      wait_done(4'b1100);
      bind_readback(a, b);
      dist_readback(idx);
    end

    // Unmapped offsets
    read_reg(8'h40, rdata, err);
    expect_value(32'(err), 32'd1, "pslverr on unmapped read");
    write_reg(8'h44, 32'hdead_beef, err);
    expect_value(32'(err), 32'd1, "pslverr on unmapped write");

    // Second command to a busy bind unit is refused
    a = rand_idx();
    b = rand_idx();
    write_reg(`HDC_REG_BIND_CMD, (32'(b) << 8) | 32'(a), err);
    read_reg(`HDC_REG_STATUS, rdata, err);
    if (rdata[0]) begin
      write_reg(`HDC_REG_BIND_CMD,
                (32'((b + 3) % `HDC_NUM_ITEMS) << 8) | 32'((a + 1) % `HDC_NUM_ITEMS), err);
      expect_value(32'(err), 32'd1, "pslverr on command to busy bind unit");
    end
    wait_done(4'b0100);
    bind_readback(a, b);

    @(negedge clk);
    if (n_checked == n_pushed) begin
      $display("TEST PASSED");
    end else begin
      $display("Some queued compares were never checked");
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- hdc_im_top.sv
/*
 * HDC item-memory subsystem top
 * Register block, bind and Hamming units sharing one item-memory port
 */
`timescale 1ns/1ps
`include "hdc_im_cfg.svh"

module hdc_im_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  hdc_im_pkg::apb_req_t apb_req_i,
  output hdc_im_pkg::apb_rsp_t apb_rsp_o
);
  import hdc_im_pkg::*;

  // Register block to units
  logic [`HDC_NUM_SETS-1:0][`HDC_SEED_W-1:0] seed;
  logic [`HDC_HV_DIM-1:0]                    query;
  logic                                      bind_start;
  logic [`HDC_IDX_W-1:0]                     bind_idx_a;
  logic [`HDC_IDX_W-1:0]                     bind_idx_b;
  logic                                      bind_finish;
  logic [`HDC_HV_DIM-1:0]                    bind_result;
  logic                                      ham_start;
  logic [`HDC_IDX_W-1:0]                     ham_idx;
  logic                                      ham_finish;
  logic [`HDC_DIST_W-1:0]                    ham_dist;

  // Shared item port
  im_req_t bind_req;
  im_req_t ham_req;
  im_req_t mem_req;
  im_rsp_t mem_rsp;
  im_rsp_t bind_rsp;
  im_rsp_t ham_rsp;
  logic    bind_gnt;
  logic    ham_gnt;

  hdc_apb_regs hdc_apb_regs_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .apb_req_i     (apb_req_i),
    .apb_rsp_o     (apb_rsp_o),
    .seed_o        (seed),
    .query_o       (query),
    .bind_start_o  (bind_start),
    .bind_idx_a_o  (bind_idx_a),
    .bind_idx_b_o  (bind_idx_b),
    .bind_finish_i (bind_finish),
    .bind_result_i (bind_result),
    .ham_start_o   (ham_start),
    .ham_idx_o     (ham_idx),
    .ham_finish_i  (ham_finish),
    .ham_dist_i    (ham_dist)
  );

  hv_bind_unit hv_bind_unit_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (bind_start),
    .idx_a_i  (bind_idx_a),
    .idx_b_i  (bind_idx_b),
    .req_o    (bind_req),
    .gnt_i    (bind_gnt),
    .rsp_i    (bind_rsp),
    .finish_o (bind_finish),
    .result_o (bind_result)
  );

  hv_hamming_unit hv_hamming_unit_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (ham_start),
    .idx_i    (ham_idx),
    .query_i  (query),
    .req_o    (ham_req),
    .gnt_i    (ham_gnt),
    .rsp_i    (ham_rsp),
    .finish_o (ham_finish),
    .dist_o   (ham_dist)
  );

  // Bind is client 0, Hamming client 1
  im_port_arbiter im_port_arbiter_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .bind_req_i (bind_req),
    .ham_req_i  (ham_req),
    .bind_gnt_o (bind_gnt),
    .ham_gnt_o  (ham_gnt),
    .mem_req_o  (mem_req),
    .mem_rsp_i  (mem_rsp),
    .bind_rsp_o (bind_rsp),
    .ham_rsp_o  (ham_rsp)
  );

  ca90_item_memory ca90_item_memory_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .seed_i (seed),
    .req_i  (mem_req),
    .rsp_o  (mem_rsp)
  );

endmodule

//--- hv_bind_unit.sv
/*
 * Bind unit
 * Fetches items A and B, returns A XOR (B rotated left by one)
 */
`timescale 1ns/1ps
`include "hdc_im_cfg.svh"

module hv_bind_unit (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   start_i,
  input  logic [`HDC_IDX_W-1:0]  idx_a_i,
  input  logic [`HDC_IDX_W-1:0]  idx_b_i,
  output hdc_im_pkg::im_req_t    req_o,
  input  logic                   gnt_i,
  input  hdc_im_pkg::im_rsp_t    rsp_i,
  output logic                   finish_o,
  output logic [`HDC_HV_DIM-1:0] result_o
);
  import hdc_im_pkg::*;

  unit_state_e            state_q;
  logic [`HDC_IDX_W-1:0]  idx_a_q;
  logic [`HDC_IDX_W-1:0]  idx_b_q;
  logic [`HDC_HV_DIM-1:0] item_a_q;
  logic [`HDC_HV_DIM-1:0] result_q;
  logic                   finish_q;

  // Request held in FETCH_A and FETCH_B until granted
  always_comb begin
    req_o.valid = (state_q == FETCH_A) || (state_q == FETCH_B);
    req_o.idx   = (state_q == FETCH_B) ? idx_b_q : idx_a_q;
  end

  // --------------------------------------------------------------------------
  // Control FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= IDLE;
      finish_q <= 1'b0;
    end else begin
      finish_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= FETCH_A;
          end
        end
        FETCH_A: begin
          if (gnt_i) begin
            state_q <= FETCH_B;
          end
        end
        FETCH_B: begin
          if (gnt_i) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          // B has arrived, result registered this edge
          if (rsp_i.valid) begin
            state_q  <= IDLE;
            finish_q <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Datapath
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && start_i) begin
      idx_a_q <= idx_a_i;
      idx_b_q <= idx_b_i;
    end
    // A always lands during FETCH_B, one cycle after its grant
    if (state_q == FETCH_B && rsp_i.valid) begin
      item_a_q <= rsp_i.data;
    end
    // Rotate B left by one, bit 0 takes the old MSB
    if (state_q == DONE && rsp_i.valid) begin
      result_q <= item_a_q ^ {rsp_i.data[`HDC_HV_DIM-2:0], rsp_i.data[`HDC_HV_DIM-1]};
    end
  end

  assign finish_o = finish_q;
  assign result_o = result_q;

endmodule

//--- hv_hamming_unit.sv
/*
 * Hamming unit
 * Fetches one item and counts the bits that differ from the query
 */
`timescale 1ns/1ps
`include "hdc_im_cfg.svh"

module hv_hamming_unit (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   start_i,
  input  logic [`HDC_IDX_W-1:0]  idx_i,
  input  logic [`HDC_HV_DIM-1:0] query_i,
  output hdc_im_pkg::im_req_t    req_o,
  input  logic                   gnt_i,
  input  hdc_im_pkg::im_rsp_t    rsp_i,
  output logic                   finish_o,
  output logic [`HDC_DIST_W-1:0] dist_o
);
  import hdc_im_pkg::*;

  unit_state_e            state_q;
  logic [`HDC_IDX_W-1:0]  idx_q;
  logic [`HDC_DIST_W-1:0] dist_q;
  logic                   finish_q;
  logic [`HDC_HV_DIM-1:0] diff;
  logic [`HDC_DIST_W-1:0] ones;

  // Request goes out in the start cycle already
  // held in FETCH_A if the port was busy
  always_comb begin
    req_o.valid = (state_q == IDLE && start_i) || (state_q == FETCH_A);
    req_o.idx   = (state_q == IDLE) ? idx_i : idx_q;
  end

  // Popcount of item XOR query
  always_comb begin
    diff = rsp_i.data ^ query_i;
    ones = '0;
    for (int k = 0; k < `HDC_HV_DIM; k++) begin
      ones = ones + {{(`HDC_DIST_W-1){1'b0}}, diff[k]};
    end
  end

  // --------------------------------------------------------------------------
  // Control FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= IDLE;
      finish_q <= 1'b0;
    end else begin
      finish_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= gnt_i ? DONE : FETCH_A;
          end
        end
        FETCH_A: begin
          if (gnt_i) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          if (rsp_i.valid) begin
            state_q  <= IDLE;
            finish_q <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Index and count registers
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && start_i) begin
      idx_q <= idx_i;
    end
    if (state_q == DONE && rsp_i.valid) begin
      dist_q <= ones;
    end
  end

  assign finish_o = finish_q;
  assign dist_o   = dist_q;

endmodule

//--- im_port_arbiter.sv
/*
 * Item-memory port arbiter
 * Round-robin between the bind and Hamming units, routes responses back
 */
`timescale 1ns/1ps

module im_port_arbiter (
  input  logic                clk_i,
  input  logic                rst_i,
  input  hdc_im_pkg::im_req_t bind_req_i,
  input  hdc_im_pkg::im_req_t ham_req_i,
  output logic                bind_gnt_o,
  output logic                ham_gnt_o,
  output hdc_im_pkg::im_req_t mem_req_o,
  input  hdc_im_pkg::im_rsp_t mem_rsp_i,
  output hdc_im_pkg::im_rsp_t bind_rsp_o,
  output hdc_im_pkg::im_rsp_t ham_rsp_o
);

  // Last served client, 1 means Hamming
  logic last_ham_q;
  // Owner of the response now in flight
  logic prev_bind_q;
  logic prev_ham_q;

  // --------------------------------------------------------------------------
  // Grant and request forwarding
  // --------------------------------------------------------------------------
  always_comb begin
    // On contention the client not served last wins
    bind_gnt_o      = bind_req_i.valid & (~ham_req_i.valid | last_ham_q);
    ham_gnt_o       = ham_req_i.valid & (~bind_req_i.valid | ~last_ham_q);
    mem_req_o.valid = bind_gnt_o | ham_gnt_o;
    mem_req_o.idx   = ham_gnt_o ? ham_req_i.idx : bind_req_i.idx;
    // Response goes only to last cycle's grantee
    bind_rsp_o.valid = mem_rsp_i.valid & prev_bind_q;
    bind_rsp_o.data  = mem_rsp_i.data;
    ham_rsp_o.valid  = mem_rsp_i.valid & prev_ham_q;
    ham_rsp_o.data   = mem_rsp_i.data;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_ham_q  <= 1'b0;
      prev_bind_q <= 1'b0;
      prev_ham_q  <= 1'b0;
    end else begin
      prev_bind_q <= bind_gnt_o;
      prev_ham_q  <= ham_gnt_o;
      if (bind_gnt_o) begin
        last_ham_q <= 1'b0;
      end else if (ham_gnt_o) begin
        last_ham_q <= 1'b1;
      end
    end
  end

endmodule
